// ==== all.f ====
logic/frame_pkg.sv
logic/byte_stream_if.sv
logic/frame_len_check.sv
logic/axis_frame_fifo.sv
logic/frame_stats.sv
logic/frame_buffer_top.sv
testbench/tb_frame_buffer.sv

// ==== testbench/tb_frame_buffer.sv ====
// Self-checking testbench for the store-and-forward frame buffer.
// A table of frames (length, sender error, sink stall mode, outcome) is
// applied in a loop. Good frames go into a model queue that the output
// monitor compares against, and the counters are checked after every frame.
`timescale 1ns/10ps

module tb_frame_buffer;
    import frame_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int MAX_ROWS   = 16;

    typedef enum logic [1:0] {STALL_NONE, STALL_HOLD, STALL_RANDOM} stall_t;
    typedef enum logic [1:0] {OUT_GOOD, OUT_BAD, OUT_OVERFLOW} outcome_t;

    typedef struct packed {
        int       len;
        bit       user;
        stall_t   stall;
        outcome_t outcome;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic [DATA_WIDTH-1:0]  s_tdata;
    logic                   s_tvalid;
    logic                   s_tlast;
    logic                   s_tuser;
    logic                   s_tready;
    logic [DATA_WIDTH-1:0]  m_tdata;
    logic                   m_tvalid;
    logic                   m_tlast;
    logic                   m_tready;
    logic [COUNT_WIDTH-1:0] good_count;
    logic [COUNT_WIDTH-1:0] bad_count;
    logic [COUNT_WIDTH-1:0] overflow_count;

    row_t rows [MAX_ROWS];
    int   row_count = 0;
    bit   table_ready = 1'b0;
    // payload and stall streams each get their own seed variable
    integer data_seed  = 47;
    integer stall_seed = 47;
    stall_t mode = STALL_NONE;

    // expected output bytes as {tlast, tdata}
    logic [DATA_WIDTH:0] model_q [$];
    logic [DATA_WIDTH:0] exp_entry;
    // previous cycle state for the hold check
    bit                    stalled = 1'b0;
    logic [DATA_WIDTH-1:0] held_data;
    logic                  held_last;

    frame_buffer_top u_frame_buffer_top (
        .clk            (clk),
        .rst            (rst),
        .s_tdata        (s_tdata),
        .s_tvalid       (s_tvalid),
        .s_tlast        (s_tlast),
        .s_tuser        (s_tuser),
        .s_tready       (s_tready),
        .m_tdata        (m_tdata),
        .m_tvalid       (m_tvalid),
        .m_tlast        (m_tlast),
        .m_tready       (m_tready),
        .good_count     (good_count),
        .bad_count      (bad_count),
        .overflow_count (overflow_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_byte(input logic [DATA_WIDTH-1:0] exp_data, input bit exp_last,
                              input string where_seen);
        if (m_tdata !== exp_data) begin
            report_failure($sformatf("MISMATCH at %0t: %s m_tdata is %h, expected %h",
                                     $time, where_seen, m_tdata, exp_data));
        end
        if (m_tlast !== exp_last) begin
            report_failure($sformatf("MISMATCH at %0t: %s m_tlast is %b, expected %b",
                                     $time, where_seen, m_tlast, exp_last));
        end
    endtask

    task automatic check_counts(input logic [COUNT_WIDTH-1:0] exp_good,
                                input logic [COUNT_WIDTH-1:0] exp_bad,
                                input logic [COUNT_WIDTH-1:0] exp_ovf);
        if (good_count !== exp_good) begin
            report_failure($sformatf("MISMATCH at %0t: good_count is %0d, expected %0d",
                                     $time, good_count, exp_good));
        end
        if (bad_count !== exp_bad) begin
            report_failure($sformatf("MISMATCH at %0t: bad_count is %0d, expected %0d",
                                     $time, bad_count, exp_bad));
        end
        if (overflow_count !== exp_ovf) begin
            report_failure($sformatf("MISMATCH at %0t: overflow_count is %0d, expected %0d",
                                     $time, overflow_count, exp_ovf));
        end
    endtask

    task automatic add_row(input int len, input bit user, input stall_t stall,
                           input outcome_t outcome);
        rows[row_count] = {len, user, stall, outcome};
        row_count++;
    endtask

    // length, sender error, sink stall mode, expected outcome
    task automatic load_table();
        add_row(2,  1'b0, STALL_NONE,   OUT_GOOD);
        add_row(17, 1'b0, STALL_NONE,   OUT_GOOD);
        add_row(40, 1'b0, STALL_NONE,   OUT_GOOD);
        add_row(1,  1'b0, STALL_NONE,   OUT_BAD);
        add_row(41, 1'b0, STALL_NONE,   OUT_BAD);
        add_row(10, 1'b1, STALL_NONE,   OUT_BAD);
        // sink held off leaves 38 bytes in RAM so 30 more cannot fit
        add_row(40, 1'b0, STALL_HOLD,   OUT_GOOD);
        add_row(30, 1'b0, STALL_HOLD,   OUT_OVERFLOW);
        add_row(17, 1'b0, STALL_NONE,   OUT_GOOD);
        add_row(25, 1'b0, STALL_RANDOM, OUT_GOOD);
        add_row(8,  1'b1, STALL_RANDOM, OUT_BAD);
        add_row(3,  1'b0, STALL_RANDOM, OUT_GOOD);
        add_row(45, 1'b0, STALL_RANDOM, OUT_BAD);
        add_row(40, 1'b0, STALL_RANDOM, OUT_GOOD);
        add_row(12, 1'b0, STALL_RANDOM, OUT_GOOD);
        table_ready = 1'b1;
    endtask

    // drives one frame and holds each byte until the handshake
    task automatic send_frame(input int len, input bit user, input bit keep);
        logic [DATA_WIDTH-1:0] payload;
        bit                    last_byte;
        for (int i = 0; i < len; i++) begin
            payload   = $random(data_seed);
            last_byte = (i == len - 1);
            s_tdata   = payload;
            s_tvalid  = 1'b1;
            s_tlast   = last_byte;
            s_tuser   = user && last_byte;
            if (keep) begin
                model_q.push_back({last_byte, payload});
            end
            @(posedge clk);
            while (!s_tready) begin
                @(posedge clk);
            end
            #2;
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        s_tuser  = 1'b0;
    endtask

    // returns just after an edge, once the monitor has popped the last byte
    task automatic wait_drained();
        while (model_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    // sink ready driven off the same edge as the stream input
    initial begin
        stall_t cur_mode;
        m_tready = 1'b1;
        forever begin
            @(posedge clk);
            // mode picked up at the edge, ready driven just after it
            cur_mode = mode;
            #2;
            case (cur_mode)
                STALL_HOLD:   m_tready = 1'b0;
                STALL_RANDOM: m_tready = (($random(stall_seed) & 3) != 0);
                default:      m_tready = 1'b1;
            endcase
        end
    end

    // output monitor reading settled values at the rising edge
    always @(posedge clk) begin
        if (!rst) begin
            if (stalled) begin
                if (m_tvalid !== 1'b1) begin
                    report_failure("m_tvalid dropped while the sink was stalling");
                end
                check_byte(held_data, held_last, "held");
            end
            if (m_tvalid && m_tready) begin
                if (model_q.size() == 0) begin
                    report_failure("an output byte appeared with no good frame pending");
                end
                exp_entry = model_q.pop_front();
                check_byte(exp_entry[DATA_WIDTH-1:0], exp_entry[DATA_WIDTH], "output");
            end
            stalled   = m_tvalid && !m_tready;
            held_data = m_tdata;
            held_last = m_tlast;
        end
    end

    // run limit of four cycles per table byte plus margin
    initial begin
        int total_bytes;
        int limit_cycles;
        total_bytes = 0;
        wait (table_ready);
        for (int i = 0; i < row_count; i++) begin
            total_bytes += rows[i].len;
        end
        limit_cycles = total_bytes * 4 + 200;
        repeat (limit_cycles) @(posedge clk);
        report_failure($sformatf("timeout: the run did not finish within %0d cycles",
                                 limit_cycles));
    end

    initial begin
        int     exp_good;
        int     exp_bad;
        int     exp_ovf;
        int     frames_done;
        stall_t prev_mode;
        exp_good    = 0;
        exp_bad     = 0;
        exp_ovf     = 0;
        frames_done = 0;
        prev_mode   = STALL_NONE;
        rst      = 1'b1;
        s_tdata  = '0;
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        s_tuser  = 1'b0;
        load_table();

        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        if (m_tvalid !== 1'b0 || s_tready !== 1'b1) begin
            report_failure("output valid or input ready wrong after reset");
        end
        check_counts('0, '0, '0);
        #2;

        for (int r = 0; r < row_count; r++) begin
            // stalled rows start from an empty FIFO
            if (rows[r].stall != STALL_NONE && prev_mode != STALL_HOLD) begin
                wait_drained();
            end
            mode = rows[r].stall;
            send_frame(rows[r].len, rows[r].user, rows[r].outcome == OUT_GOOD);
            case (rows[r].outcome)
                OUT_GOOD: exp_good++;
                OUT_BAD:  exp_bad++;
                default:  exp_ovf++;
            endcase
            frames_done++;
            // status pulse then counter take one cycle each
            while (int'(good_count) + int'(bad_count) + int'(overflow_count) != frames_done) begin
                @(posedge clk);
            end
            check_counts(exp_good, exp_bad, exp_ovf);
            prev_mode = rows[r].stall;
            #2;
        end

        mode = STALL_NONE;
        // output register empties once every committed byte has left
        @(posedge clk);
        while (m_tvalid) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        check_counts(exp_good, exp_bad, exp_ovf);
        if (model_q.size() != 0) begin
            report_failure("expected bytes never came out of the FIFO");
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== logic/frame_buffer_top.sv ====
// Top level of the store-and-forward packet buffer.
// Plain stream ports on both sides. Input runs through the length checker
// into the frame FIFO, and the FIFO status pulses feed the statistics.
// The FIFO drops frames that do not fit, so s_tready stays high.
`timescale 1ns/10ps

module frame_buffer_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [frame_pkg::DATA_WIDTH-1:0]  s_tdata,
    input  logic                             s_tvalid,
    input  logic                             s_tlast,
    input  logic                             s_tuser,
    output logic                             s_tready,
    output logic [frame_pkg::DATA_WIDTH-1:0]  m_tdata,
    output logic                             m_tvalid,
    output logic                             m_tlast,
    input  logic                             m_tready,
    output logic [frame_pkg::COUNT_WIDTH-1:0] good_count,
    output logic [frame_pkg::COUNT_WIDTH-1:0] bad_count,
    output logic [frame_pkg::COUNT_WIDTH-1:0] overflow_count
);

    // raw input and checked stream
    byte_stream_if in_stream ();
    byte_stream_if chk_stream ();

    // one-cycle status pulses from the FIFO
    logic overflow;
    logic bad_frame;
    logic good_frame;

    assign in_stream.tdata  = s_tdata;
    assign in_stream.tvalid = s_tvalid;
    assign in_stream.tlast  = s_tlast;
    assign in_stream.tuser  = s_tuser;
    assign s_tready         = in_stream.tready;

    frame_len_check u_frame_len_check (
        .clk  (clk),
        .rst  (rst),
        .up   (in_stream.sink),
        .down (chk_stream.source)
    );

    axis_frame_fifo #(
        .drop_when_full (1'b1)
    ) u_axis_frame_fifo (
        .clk        (clk),
        .rst        (rst),
        .wr         (chk_stream.sink),
        .m_tdata    (m_tdata),
        .m_tvalid   (m_tvalid),
        .m_tlast    (m_tlast),
        .m_tready   (m_tready),
        .overflow   (overflow),
        .bad_frame  (bad_frame),
        .good_frame (good_frame)
    );

    frame_stats u_frame_stats (
        .clk            (clk),
        .rst            (rst),
        .overflow       (overflow),
        .bad_frame      (bad_frame),
        .good_frame     (good_frame),
        .good_count     (good_count),
        .bad_count      (bad_count),
        .overflow_count (overflow_count)
    );

endmodule

// ==== logic/frame_stats.sv ====
// Frame statistics behind the frame FIFO.
// Each status pulse bumps its own counter one cycle later.
// Counters have no clear and simply wrap at COUNT_WIDTH bits.
`timescale 1ns/10ps

module frame_stats (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             overflow,
    input  logic                             bad_frame,
    input  logic                             good_frame,
    output logic [frame_pkg::COUNT_WIDTH-1:0] good_count,
    output logic [frame_pkg::COUNT_WIDTH-1:0] bad_count,
    output logic [frame_pkg::COUNT_WIDTH-1:0] overflow_count
);

    // frames committed to the FIFO
    always_ff @(posedge clk) begin
        if (rst) begin
            good_count <= '0;
        end else if (good_frame) begin
            good_count <= good_count + 1'b1;
        end
    end

    // frames rolled back for length or sender error
    always_ff @(posedge clk) begin
        if (rst) begin
            bad_count <= '0;
        end else if (bad_frame) begin
            bad_count <= bad_count + 1'b1;
        end
    end

    // frames dropped for lack of space
    always_ff @(posedge clk) begin
        if (rst) begin
            overflow_count <= '0;
        end else if (overflow) begin
            overflow_count <= overflow_count + 1'b1;
        end
    end

    // FIFO closes at most one frame per cycle
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({overflow, bad_frame, good_frame}));

endmodule

// ==== logic/axis_frame_fifo.sv ====
// Store-and-forward frame FIFO.
// Bytes of a frame are written ahead of the committed pointer and only become
// readable once a good last byte commits them. Bad frames roll back whole.
// Frames that run out of space are dropped and reported as overflow.
// A read register and an output register sit behind the RAM.
`timescale 1ns/10ps

module axis_frame_fifo #(
    // 1 keeps wr.tready high and drops frames that do not fit
    parameter bit drop_when_full = 1'b0
) (
    input  logic                            clk,
    input  logic                            rst,
    byte_stream_if.sink                     wr,
    output logic [frame_pkg::DATA_WIDTH-1:0] m_tdata,
    output logic                            m_tvalid,
    output logic                            m_tlast,
    input  logic                            m_tready,
    output logic                            overflow,
    output logic                            bad_frame,
    output logic                            good_frame
);
    import frame_pkg::*;

    // extra top bit tells full from empty
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] wr_ptr_next;
    logic [ADDR_WIDTH:0] wr_ptr_cur;
    logic [ADDR_WIDTH:0] wr_ptr_cur_next;
    logic [ADDR_WIDTH:0] rd_ptr;
    logic [ADDR_WIDTH:0] rd_ptr_next;

    // entry is {tlast, tdata}
    logic [DATA_WIDTH:0] mem [2**ADDR_WIDTH];
    logic [DATA_WIDTH:0] rd_data;
    logic                rd_valid;
    logic                rd_valid_next;
    logic [DATA_WIDTH:0] out_data;
    logic                out_valid_next;

    logic full;
    logic full_cur;
    logic empty;
    logic accept;
    logic mem_we;
    logic mem_re;
    logic store_output;

    logic drop_frame;
    logic drop_frame_next;
    logic overflow_next;
    logic bad_frame_next;
    logic good_frame_next;

    // no room even for a new frame
    assign full = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                  (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);
    // frame in progress has caught up with the read side
    assign full_cur = (wr_ptr_cur[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                      (wr_ptr_cur[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);
    // only committed data counts for the reader
    assign empty = (wr_ptr == rd_ptr);

    assign wr.tready = !full || drop_when_full;
    assign accept    = wr.tvalid && wr.tready;

    assign {m_tlast, m_tdata} = out_data;

    // write side
    always_comb begin
        mem_we          = 1'b0;
        wr_ptr_next     = wr_ptr;
        wr_ptr_cur_next = wr_ptr_cur;
        drop_frame_next = drop_frame;
        overflow_next   = 1'b0;
        bad_frame_next  = 1'b0;
        good_frame_next = 1'b0;

        if (accept) begin
            // full implies full_cur, since the current pointer never trails
            if (full_cur || drop_frame) begin
                // discard the rest of this frame
                drop_frame_next = 1'b1;
                if (wr.tlast) begin
                    wr_ptr_cur_next = wr_ptr;
                    drop_frame_next = 1'b0;
                    overflow_next   = 1'b1;
                end
            end else begin
                mem_we          = 1'b1;
                wr_ptr_cur_next = wr_ptr_cur + 1'b1;
                if (wr.tlast) begin
                    if (wr.tuser) begin
                        // bad frame, roll back
                        wr_ptr_cur_next = wr_ptr;
                        bad_frame_next  = 1'b1;
                    end else begin
                        // good frame, make it visible to the reader
                        wr_ptr_next     = wr_ptr_cur + 1'b1;
                        good_frame_next = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            wr_ptr_cur <= '0;
            drop_frame <= 1'b0;
            overflow   <= 1'b0;
            bad_frame  <= 1'b0;
            good_frame <= 1'b0;
        end else begin
            wr_ptr     <= wr_ptr_next;
            wr_ptr_cur <= wr_ptr_cur_next;
            drop_frame <= drop_frame_next;
            overflow   <= overflow_next;
            bad_frame  <= bad_frame_next;
            good_frame <= good_frame_next;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[wr_ptr_cur[ADDR_WIDTH-1:0]] <= {wr.tlast, wr.tdata};
        end
    end

    // read side, refill the read register whenever it empties or moves on
    always_comb begin
        mem_re        = 1'b0;
        rd_ptr_next   = rd_ptr;
        rd_valid_next = rd_valid;

        if (store_output || !rd_valid) begin
            if (!empty) begin
                mem_re        = 1'b1;
                rd_valid_next = 1'b1;
                rd_ptr_next   = rd_ptr + 1'b1;
            end else begin
                rd_valid_next = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_ptr   <= rd_ptr_next;
            rd_valid <= rd_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_re) begin
            rd_data <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    // output register, loads when empty or when the sink takes a byte
    assign store_output   = m_tready || !m_tvalid;
    assign out_valid_next = store_output ? rd_valid : m_tvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_tvalid <= 1'b0;
        end else begin
            m_tvalid <= out_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_output) begin
            out_data <= rd_data;
        end
    end

    // a write never pushes the held data past the RAM depth
    assert property (@(posedge clk) disable iff (rst)
        mem_we |=> (wr_ptr_cur - rd_ptr) <= (ADDR_WIDTH + 1)'(2**ADDR_WIDTH));

    // stalled output keeps every field
    assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready
        |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast));

endmodule

// ==== logic/frame_len_check.sv ====
// Frame length checker placed in front of the frame FIFO.
// The stream passes through with no latency. On the last byte of a frame,
// tuser is raised when the frame is shorter than MIN_FRAME_LEN, longer than
// MAX_FRAME_LEN, or already flagged bad by the sender.
`timescale 1ns/10ps

module frame_len_check (
    input  logic          clk,
    input  logic          rst,
    byte_stream_if.sink   up,
    byte_stream_if.source down
);
    import frame_pkg::*;

    len_state_t           state;
    len_state_t           state_next;
    // bytes accepted so far in the current frame
    logic [LEN_WIDTH-1:0] len_cnt;
    logic [LEN_WIDTH-1:0] len_cnt_next;
    // frame length including the byte now on the bus
    logic [LEN_WIDTH-1:0] len_now;
    logic                 accept;
    logic                 too_short;
    logic                 too_long;
    logic                 len_err;

    // data path is a straight copy
    assign down.tdata  = up.tdata;
    assign down.tvalid = up.tvalid;
    assign down.tlast  = up.tlast;
    assign up.tready   = down.tready;

    assign accept = up.tvalid && down.tready;

    // once too long the count stays parked at MAX_FRAME_LEN + 1
    assign len_now = (state == ST_TOO_LONG) ? len_cnt : len_cnt + 1'b1;

    assign too_short = len_now < LEN_WIDTH'(MIN_FRAME_LEN);
    assign too_long  = len_now > LEN_WIDTH'(MAX_FRAME_LEN);
    assign len_err   = too_short || too_long;

    // length error only counts on the closing byte
    assign down.tuser = up.tuser || (up.tlast && len_err);

    always_comb begin
        state_next   = state;
        len_cnt_next = len_cnt;

        if (accept) begin
            if (up.tlast) begin
                // frame done so the next byte starts a fresh one
                state_next   = ST_FIRST;
                len_cnt_next = '0;
            end else begin
                len_cnt_next = len_now;
                if (too_long) begin
                    state_next = ST_TOO_LONG;
                end else begin
                    state_next = ST_BODY;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_FIRST;
            len_cnt <= '0;
        end else begin
            state   <= state_next;
            len_cnt <= len_cnt_next;
        end
    end

    // saturation bound of the counter
    assert property (@(posedge clk) disable iff (rst)
        len_cnt <= LEN_WIDTH'(MAX_FRAME_LEN + 1));

endmodule

// ==== logic/byte_stream_if.sv ====
// Byte-wide stream link with a valid/ready handshake, last and user flags.
// A byte moves on a rising edge where tvalid and tready are both high.
// The source holds tvalid and every data field steady until that edge.
`timescale 1ns/10ps

interface byte_stream_if;
    import frame_pkg::*;

    logic [DATA_WIDTH-1:0] tdata;
    logic                  tvalid;
    logic                  tready;
    // marks the final byte of a frame
    logic                  tlast;
    // error flag, only meaningful together with tlast
    logic                  tuser;

    modport source (
        output tdata,
        output tvalid,
        output tlast,
        output tuser,
        input  tready
    );

    modport sink (
        input  tdata,
        input  tvalid,
        input  tlast,
        input  tuser,
        output tready
    );

endinterface

// ==== logic/frame_pkg.sv ====
// Shared constants and types for the store-and-forward frame buffer.
// Compile this package first. Modules pull it in with a wildcard import
// in their body and use scoped names in their port lists.
package frame_pkg;

    // byte-wide stream
    localparam int DATA_WIDTH = 8;

    // 64 RAM entries, each holding one data byte plus its last flag
    localparam int ADDR_WIDTH = 6;

    // legal frame length range, in bytes
    localparam int MIN_FRAME_LEN = 2;
    localparam int MAX_FRAME_LEN = 40;

    // checker byte counter
    // it saturates at MAX_FRAME_LEN + 1, so 6 bits are enough
    localparam int LEN_WIDTH = 6;

    // statistics counters wrap at this width
    localparam int COUNT_WIDTH = 16;

    // position of the length checker within the current frame
    typedef enum logic [1:0] {
        // next accepted byte opens a new frame
        ST_FIRST,
        // inside a frame that is still within the length limit
        ST_BODY,
        // frame already longer than MAX_FRAME_LEN
        ST_TOO_LONG
    } len_state_t;

endpackage
